// File: logic/pool_pkg.sv
package pool_pkg;

    // Window geometry fixed by the bitonic schedule
    localparam int PIXEL_W     = 16;
    localparam int WIN_PIXELS  = 9;
    localparam int SORT_PIXELS = 8;

    typedef logic [PIXEL_W-1:0]             pixel_t;        // fp16 sign, exponent, mantissa
    typedef logic [WIN_PIXELS*PIXEL_W-1:0]  pool_window_t;  // Pixel k at slice k from LSB
    typedef logic [$clog2(SORT_PIXELS)-1:0] sort_idx_t;

    // Sorter progress with one state per bitonic stage
    typedef enum logic [2:0] {
        SORT_IDLE   = 3'd0,
        SORT_STAGE1 = 3'd1,
        SORT_STAGE2 = 3'd2,
        SORT_STAGE3 = 3'd3,
        SORT_STAGE4 = 3'd4,
        SORT_STAGE5 = 3'd5,
        SORT_STAGE6 = 3'd6
    } sort_state_t;

    // Strict ordering of two finite fp16 values
    // Sign-magnitude encoding lets the magnitude bits compare as unsigned integers
    function automatic logic fp16_greater(input pixel_t a, input pixel_t b);
        logic               a_neg;
        logic               b_neg;
        logic [PIXEL_W-2:0] a_mag;
        logic [PIXEL_W-2:0] b_mag;
        logic               gt;

        a_neg = a[PIXEL_W-1];
        b_neg = b[PIXEL_W-1];
        a_mag = a[PIXEL_W-2:0];
        b_mag = b[PIXEL_W-2:0];

        if (a_neg != b_neg) begin
            gt = !a_neg && ((a_mag != '0) || (b_mag != '0));  // +0 equals -0
        end else if (!a_neg) begin
            gt = a_mag > b_mag;
        end else begin
            gt = a_mag < b_mag;  // Both negative
        end
        return gt;
    endfunction

endpackage

// File: logic/window_capture.sv
`timescale 1ns/1ps

module window_capture import pool_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_start,
    input  pool_window_t i_window,
    input  logic         i_release,
    output pool_window_t o_window_q,
    output logic         o_load,
    output logic         o_busy
);

    logic         busy_q;
    logic         load_q;
    pool_window_t window_q;
    logic         accept;

    // Release and a new start may land on the same edge
    assign accept = i_start && (!busy_q || i_release);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            load_q <= 1'b0;
        end else begin
            load_q <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (i_release) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Window held for the sorter and the final compare
    always_ff @(posedge clk) begin
        if (accept) begin
            window_q <= i_window;
        end
    end

    assign o_window_q = window_q;
    assign o_load     = load_q;
    assign o_busy     = busy_q;

endmodule

// File: logic/bitonic_sorter.sv
`timescale 1ns/1ps

module bitonic_sorter import pool_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_load,
    input  pool_window_t i_window,
    output pixel_t       o_max8,
    output logic         o_done
);

    localparam int CMP_N = SORT_PIXELS / 2;  // Compare-exchange units per stage

    sort_state_t      state_q;
    sort_state_t      state_nxt;
    pixel_t           pix     [SORT_PIXELS];
    sort_idx_t        idx_q   [SORT_PIXELS];
    sort_idx_t        idx_cur [SORT_PIXELS];
    sort_idx_t        idx_nxt [SORT_PIXELS];
    sort_idx_t        lo_pos  [CMP_N];
    sort_idx_t        hi_pos  [CMP_N];
    logic [CMP_N-1:0] desc;
    logic [CMP_N-1:0] swap;
    logic             step;

    // Pixels 0 to 7 of the latched window
    always_comb begin
        for (int k = 0; k < SORT_PIXELS; k++) begin
            pix[k] = i_window[k*PIXEL_W +: PIXEL_W];
        end
    end

    // Stage 1 runs on the load edge straight from the identity order
    always_comb begin
        for (int p = 0; p < SORT_PIXELS; p++) begin
            idx_cur[p] = (state_q == SORT_IDLE) ? sort_idx_t'(p) : idx_q[p];
        end
    end

    assign step = (state_q == SORT_IDLE) ? i_load : (state_q != SORT_STAGE6);

    // Pairings of the stage that runs on the next edge
    // desc set means the larger value goes to the lower position
    always_comb begin
        case (state_q)
            SORT_IDLE: begin
                lo_pos = '{3'd0, 3'd2, 3'd4, 3'd6};
                hi_pos = '{3'd1, 3'd3, 3'd5, 3'd7};
                desc   = 4'b1010;
            end
            SORT_STAGE1: begin
                lo_pos = '{3'd0, 3'd1, 3'd4, 3'd5};
                hi_pos = '{3'd2, 3'd3, 3'd6, 3'd7};
                desc   = 4'b1100;
            end
            SORT_STAGE2: begin
                lo_pos = '{3'd0, 3'd2, 3'd4, 3'd6};
                hi_pos = '{3'd1, 3'd3, 3'd5, 3'd7};
                desc   = 4'b1100;
            end
            SORT_STAGE3: begin  // Final merge of both halves
                lo_pos = '{3'd0, 3'd1, 3'd2, 3'd3};
                hi_pos = '{3'd4, 3'd5, 3'd6, 3'd7};
                desc   = 4'b0000;
            end
            SORT_STAGE4: begin
                lo_pos = '{3'd0, 3'd1, 3'd4, 3'd5};
                hi_pos = '{3'd2, 3'd3, 3'd6, 3'd7};
                desc   = 4'b0000;
            end
            default: begin
                lo_pos = '{3'd0, 3'd2, 3'd4, 3'd6};
                hi_pos = '{3'd1, 3'd3, 3'd5, 3'd7};
                desc   = 4'b0000;
            end
        endcase
    end

    // Four compare-exchanges that move indices and leave pixels in place
    always_comb begin
        pixel_t lo_pix;
        pixel_t hi_pix;

        idx_nxt = idx_cur;
        for (int c = 0; c < CMP_N; c++) begin
            lo_pix = pix[idx_cur[lo_pos[c]]];
            hi_pix = pix[idx_cur[hi_pos[c]]];
            if (desc[c]) begin
                swap[c] = fp16_greater(hi_pix, lo_pix);
            end else begin
                swap[c] = fp16_greater(lo_pix, hi_pix);
            end
            if (swap[c]) begin
                idx_nxt[lo_pos[c]] = idx_cur[hi_pos[c]];
                idx_nxt[hi_pos[c]] = idx_cur[lo_pos[c]];
            end
        end
    end

    always_comb begin
        case (state_q)
            SORT_IDLE:   state_nxt = i_load ? SORT_STAGE1 : SORT_IDLE;
            SORT_STAGE1: state_nxt = SORT_STAGE2;
            SORT_STAGE2: state_nxt = SORT_STAGE3;
            SORT_STAGE3: state_nxt = SORT_STAGE4;
            SORT_STAGE4: state_nxt = SORT_STAGE5;
            SORT_STAGE5: state_nxt = SORT_STAGE6;
            default:     state_nxt = SORT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SORT_IDLE;
            for (int p = 0; p < SORT_PIXELS; p++) begin
                idx_q[p] <= sort_idx_t'(p);
            end
        end else begin
            state_q <= state_nxt;
            if (step) begin
                idx_q <= idx_nxt;
            end
        end
    end

    // State names the last stage done
    assign o_done = (state_q == SORT_STAGE6);
    assign o_max8 = pix[idx_q[SORT_PIXELS-1]];  // Largest ends at position 7

endmodule

// File: logic/max_select.sv
`timescale 1ns/1ps

module max_select import pool_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_done,
    input  pixel_t       i_max8,
    input  pool_window_t i_window,
    output pixel_t       o_result,
    output logic         o_valid
);

    pixel_t pix8;
    pixel_t winner;
    pixel_t result_q;
    logic   valid_q;

    // Pixel 8 sits outside the bitonic network
    assign pix8 = i_window[(WIN_PIXELS-1)*PIXEL_W +: PIXEL_W];

    // Ties go to pixel 8
    assign winner = fp16_greater(i_max8, pix8) ? i_max8 : pix8;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= i_done;  // Single pulse per window
            if (i_done) begin
                result_q <= winner;
            end
        end
    end

    assign o_result = result_q;
    assign o_valid  = valid_q;

endmodule

// File: logic/max_pool_3x3.sv
`timescale 1ns/1ps

module max_pool_3x3 import pool_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_start,
    input  pool_window_t i_window,
    output logic         o_busy,
    output logic         o_valid,
    output pixel_t       o_result
);

    pool_window_t window_q;
    logic         load;
    logic         done;
    pixel_t       max8;

    window_capture capture_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_start    (i_start),
        .i_window   (i_window),
        .i_release  (o_valid),   // Result out frees the unit
        .o_window_q (window_q),
        .o_load     (load),
        .o_busy     (o_busy)
    );

    bitonic_sorter sorter_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_load   (load),
        .i_window (window_q),
        .o_max8   (max8),
        .o_done   (done)
    );

    max_select select_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_done   (done),
        .i_max8   (max8),
        .i_window (window_q),
        .o_result (o_result),
        .o_valid  (o_valid)
    );

endmodule

// File: tests/max_pool_assert.sv
`timescale 1ns/1ps

module max_pool_assert (
    input logic clk,
    input logic rst_n,
    input logic i_start,
    input logic i_busy,
    input logic i_valid
);

    logic accept;

    // Start taken when idle or on the releasing edge
    assign accept = i_start && (!i_busy || i_valid);

    valid_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) i_valid |=> !i_valid
    ) else $error("o_valid high for two cycles in a row");

    valid_after_start: assert property (
        @(posedge clk) disable iff (!rst_n) accept |-> ##8 $rose(i_valid)
    ) else $error("o_valid did not rise 8 cycles after an accepted start");

    idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !i_busy
    ) else $error("o_busy not low after reset");

endmodule

bind max_pool_3x3 max_pool_assert assert_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_start (i_start),
    .i_busy  (o_busy),
    .i_valid (o_valid)
);

// File: tests/tb_max_pool.sv
`timescale 1ns/1ps

module tb_max_pool;
    import pool_pkg::*;

    localparam int          NUM_WINDOWS  = 64;  // 9 + 3 + 1 + 1 + 50
    localparam int          RESET_MARGIN = 20;
    localparam int          CYCLE_LIMIT  = 40 * NUM_WINDOWS + RESET_MARGIN;
    localparam int          VALID_WAIT   = 20;
    localparam logic [31:0] SEED         = 32'h3ed8_8738;

    logic         clk;
    logic         rst_n;
    logic         i_start;
    pool_window_t i_window;
    logic         o_busy;
    logic         o_valid;
    pixel_t       o_result;
    int           cycles;

    max_pool_3x3 dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_start  (i_start),
        .i_window (i_window),
        .o_busy   (o_busy),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopping at first error");
    endtask

    // Watchdog
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                abort_run($sformatf("Run did not end within %0d cycles", CYCLE_LIMIT));
            end
        end
    end

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp));
        end
    endtask

    // fp16 ordering by sign and then magnitude with +0 equal to -0
    function automatic logic ref_greater(input pixel_t a, input pixel_t b);
        logic        a_pos;
        logic        b_pos;
        logic [14:0] a_abs;
        logic [14:0] b_abs;
        logic        result;

        a_pos = (a[15] == 1'b0);
        b_pos = (b[15] == 1'b0);
        a_abs = a[14:0];
        b_abs = b[14:0];
        if (a_pos && !b_pos) begin
            result = (a_abs != 15'd0) || (b_abs != 15'd0);
        end else if (!a_pos && b_pos) begin
            result = 1'b0;
        end else if (a_pos) begin
            result = a_abs > b_abs;
        end else begin
            result = a_abs < b_abs;  // Closer to zero wins
        end
        return result;
    endfunction

    function automatic pixel_t ref_max(input pool_window_t w);
        pixel_t best;
        pixel_t cand;

        best = w[PIXEL_W-1:0];
        for (int k = 1; k < WIN_PIXELS; k++) begin
            cand = w[k*PIXEL_W +: PIXEL_W];
            if (ref_greater(cand, best)) begin
                best = cand;
            end
        end
        return best;
    endfunction

    function automatic pool_window_t pack_window(input pixel_t vals [WIN_PIXELS]);
        pool_window_t w;

        for (int k = 0; k < WIN_PIXELS; k++) begin
            w[k*PIXEL_W +: PIXEL_W] = vals[k];
        end
        return w;
    endfunction

    // Finite values only and no negative zero
    function automatic pixel_t rand_pixel();
        logic [31:0] r;
        logic [31:0] e;
        pixel_t      p;

        r = $urandom;
        e = $urandom_range(30, 0);  // Exponent 31 is Inf/NaN
        p = {r[15], e[4:0], r[9:0]};
        if (p == 16'h8000) begin
            p = 16'h0000;
        end
        return p;
    endfunction

    // Returns at the edge that samples the start
    task automatic send_window(input pool_window_t w);
        @(posedge clk);
        i_start  <= 1'b1;
        i_window <= w;
        @(posedge clk);
        i_start  <= 1'b0;
    endtask

    task automatic wait_for_valid();
        int n;

        n = 0;
        while (1) begin
            @(negedge clk);
            n++;
            if (o_valid) begin
                break;
            end
            if (n >= VALID_WAIT) begin
                abort_run($sformatf("o_valid did not arrive within %0d cycles", VALID_WAIT));
            end
        end
    endtask

    task automatic run_window(input pool_window_t w);
        send_window(w);
        wait_for_valid();
        check_pixel("o_result", o_result, ref_max(w));
    endtask

    task automatic positive_max_sweep();
        pixel_t base[WIN_PIXELS];
        pixel_t vals[WIN_PIXELS];

        base = '{16'h3C00, 16'h3E00, 16'h4000, 16'h4100, 16'h4200,
                 16'h4300, 16'h3800, 16'h3400, 16'h4400};
        for (int p = 0; p < WIN_PIXELS; p++) begin
            vals    = base;
            vals[p] = 16'h5A40;  // 200.0
            run_window(pack_window(vals));
        end
    endtask

    task automatic mixed_sign_windows();
        pixel_t vals[WIN_PIXELS];

        vals = '{16'hC000, 16'hBC00, 16'h8000, 16'h0000, 16'hC500,
                 16'hD000, 16'hB800, 16'hE000, 16'h3555};
        run_window(pack_window(vals));
        vals = '{16'h8000, 16'hC000, 16'h0000, 16'h3555, 16'hBC00,
                 16'hE000, 16'hB800, 16'hD000, 16'hC500};
        run_window(pack_window(vals));
        // All negative with -0.03125 the smallest magnitude
        vals = '{16'hC000, 16'hBC00, 16'hB400, 16'hC800, 16'hA800,
                 16'hD400, 16'hBE00, 16'hC200, 16'hB000};
        run_window(pack_window(vals));
        check_pixel("o_result", o_result, 16'hA800);
    endtask

    task automatic latency_pulse();
        pixel_t       vals[WIN_PIXELS];
        pool_window_t w;

        vals = '{16'h4A00, 16'h3C00, 16'h4D00, 16'hC400, 16'h4900,
                 16'h0000, 16'h4B80, 16'hBC00, 16'h4200};
        w    = pack_window(vals);
        send_window(w);
        for (int n = 1; n <= 9; n++) begin
            @(negedge clk);
            check_bit("o_valid", o_valid, n == 8);
            check_bit("o_busy", o_busy, n <= 8);
            if (n == 8) begin
                check_pixel("o_result", o_result, ref_max(w));
            end
        end
    endtask

    task automatic busy_ignores_start();
        pixel_t       first_vals[WIN_PIXELS];
        pixel_t       second_vals[WIN_PIXELS];
        pool_window_t first_w;
        pool_window_t second_w;

        first_vals  = '{16'h3C00, 16'h4000, 16'h4200, 16'h4400, 16'h4500,
                        16'h4600, 16'h4700, 16'h4800, 16'h3800};
        second_vals = '{16'h6000, 16'h5000, 16'h5400, 16'h5800, 16'h5C00,
                        16'h4C00, 16'h4E00, 16'h5200, 16'h5600};
        first_w     = pack_window(first_vals);
        second_w    = pack_window(second_vals);
        send_window(first_w);
        @(posedge clk);
        i_start  <= 1'b1;
        i_window <= second_w;
        @(posedge clk);  // Sampled while busy
        i_start  <= 1'b0;
        @(negedge clk);
        check_bit("o_busy", o_busy, 1'b1);
        wait_for_valid();
        check_pixel("o_result", o_result, ref_max(first_w));
        repeat (12) begin
            @(negedge clk);
            check_bit("o_valid", o_valid, 1'b0);
        end
        check_bit("o_busy", o_busy, 1'b0);
    endtask

    task automatic random_windows();
        pixel_t vals[WIN_PIXELS];

        for (int t = 0; t < 50; t++) begin
            for (int k = 0; k < WIN_PIXELS; k++) begin
                vals[k] = rand_pixel();
            end
            run_window(pack_window(vals));
        end
    endtask

    initial begin
        int seed_ret;

        seed_ret = $urandom(SEED);
        rst_n    = 1'b0;
        i_start  = 1'b0;
        i_window = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_valid", o_valid, 1'b0);
        check_pixel("o_result", o_result, 16'h0000);

        positive_max_sweep();
        mixed_sign_windows();
        latency_pulse();
        busy_ignores_start();
        random_windows();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: build.f
logic/pool_pkg.sv
logic/window_capture.sv
logic/bitonic_sorter.sv
logic/max_select.sv
logic/max_pool_3x3.sv
tests/max_pool_assert.sv
tests/tb_max_pool.sv

// File: Makefile
# Verilator simulation of the 3x3 max-pooling unit

VERILATOR ?= verilator
TOP       ?= tb_max_pool
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
